/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lcd_display
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/button_sync.sv */
`timescale 1ns/10ps
`default_nettype none

module button_sync (
    input  logic clk,
    input  logic nrst,
    input  logic btn,
    output logic rise
);

    logic [1:0] sync_q;
    logic       last_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sync_q <= 2'b00;
            last_q <= 1'b0;
            rise   <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], btn};
            last_q <= sync_q[1];
            rise   <= sync_q[1] & ~last_q;  // one cycle per press.
        end
    end

endmodule

`default_nettype wire

/* design/display_control.sv */
`timescale 1ns/10ps
`default_nettype none

module display_control import lcd_pkg::*; (
    input  logic clk,
    input  logic nrst,
    input  logic init_done,
    input  logic paint_done,
    input  logic cell_changed,
    input  logic game_over,
    input  logic restart_pulse,
    output logic init_start,
    output logic paint_start,
    output logic scan_en,
    output logic frame_clear
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    ctrl_state_t prev_state;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state      <= INIT;
            prev_state <= OVER;  // makes the first cycle an INIT entry.
        end else begin
            state      <= next_state;
            prev_state <= state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            INIT: if (init_done) next_state = LOOP;
            LOOP: begin
                if (game_over)
                    next_state = OVER;
                else if (cell_changed)
                    next_state = UPDATE;
            end
            UPDATE: if (paint_done) next_state = LOOP;
            OVER:   if (restart_pulse) next_state = INIT;
            default: next_state = INIT;
        endcase
    end

    // start pulses on state entry.
    assign init_start  = (state == INIT) && (prev_state != INIT);
    assign paint_start = (state == UPDATE) && (prev_state != UPDATE);

    assign scan_en     = (state == LOOP) && !cell_changed && !game_over;
    assign frame_clear = (state == INIT) || (state == OVER);  // frame empty until the scan.

endmodule

`default_nettype wire

/* design/frame_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_tracker import lcd_pkg::*; #(
    parameter int GRID_W = 16,
    parameter int GRID_H = 12
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic       scan_en,
    input  logic       frame_clear,
    input  logic       head,
    input  logic       body,
    input  logic       apple,
    input  logic       border,
    output logic [3:0] x,
    output logic [3:0] y,
    output obj_t       cell_obj,
    output logic       cell_changed
);

    obj_t frame [GRID_H][GRID_W];  // last object painted per cell.
    obj_t stored;

    // ======================================================================
    // scan counters.
    // ======================================================================
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            x <= 4'd0;
            y <= 4'd0;
        end else if (frame_clear) begin
            x <= 4'd0;
            y <= 4'd0;
        end else if (scan_en) begin
            if (x == 4'(GRID_W - 1)) begin
                x <= 4'd0;
                y <= (y == 4'(GRID_H - 1)) ? 4'd0 : y + 4'd1;
            end else begin
                x <= x + 4'd1;
            end
        end
    end

    // ======================================================================
    // object priority and change detection.
    // ======================================================================
    always_comb begin
        if (border)
            cell_obj = BORDER;
        else if (head)
            cell_obj = HEAD;
        else if (body)
            cell_obj = BODY;
        else if (apple)
            cell_obj = APPLE;
        else
            cell_obj = EMPTY;
    end

    assign stored       = frame[y][x];
    assign cell_changed = (stored != cell_obj);

    always_ff @(posedge clk) begin
        if (frame_clear)
            frame <= '{default: EMPTY};
        else
            frame[y][x] <= cell_obj;  // x,y hold while a repaint runs.
    end

endmodule

`default_nettype wire

/* design/init_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module init_sequencer import lcd_pkg::*; #(
    parameter int GRID_W      = 16,
    parameter int GRID_H      = 12,
    parameter int TILE_PX     = 20,
    parameter int WAIT_CYCLES = 60000
) (
    input  logic          clk,
    input  logic          nrst,
    input  logic          start,
    lcd_bus_if.client     bus,
    output logic          done
);

    localparam int CLEAR_BYTES = 2 * GRID_W * GRID_H * TILE_PX * TILE_PX;
    localparam int PIX_W       = $clog2(CLEAR_BYTES + 1);
    localparam int WAIT_W      = $clog2(WAIT_CYCLES + 1);
    localparam logic [4:0]  STEP_PIX = 5'd16;  // first pixel step.
    localparam logic [15:0] COL_END  = 16'(GRID_W * TILE_PX - 1);
    localparam logic [15:0] PAGE_END = 16'(GRID_H * TILE_PX - 1);

    wr_phase_t         phase;
    logic              busy;
    logic              waiting;
    logic [4:0]        step;
    logic [PIX_W-1:0]  pix_cnt;
    logic [WAIT_W-1:0] wait_cnt;
    lcd_byte_t         cur;

    // ======================================================================
    // command list.
    // ======================================================================
    always_comb begin
        case (step)
            5'd0:    cur = {1'b0, CMD_SWRESET};
            5'd1:    cur = {1'b0, CMD_SLPOUT};
            5'd2:    cur = {1'b0, CMD_COLMOD};
            5'd3:    cur = {1'b1, PIXEL_FORMAT};
            5'd4:    cur = {1'b0, CMD_DISPON};
            5'd5:    cur = {1'b0, CMD_CASET};
            5'd6:    cur = {1'b1, 8'h00};
            5'd7:    cur = {1'b1, 8'h00};
            5'd8:    cur = {1'b1, COL_END[15:8]};
            5'd9:    cur = {1'b1, COL_END[7:0]};
            5'd10:   cur = {1'b0, CMD_PASET};
            5'd11:   cur = {1'b1, 8'h00};
            5'd12:   cur = {1'b1, 8'h00};
            5'd13:   cur = {1'b1, PAGE_END[15:8]};
            5'd14:   cur = {1'b1, PAGE_END[7:0]};
            5'd15:   cur = {1'b0, CMD_RAMWR};
            default: cur = {1'b1, pix_cnt[0] ? COLOR_EMPTY[15:8] : COLOR_EMPTY[7:0]};
        endcase
    end

    // ======================================================================
    // byte emission.
    // ======================================================================
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            busy     <= 1'b0;
            waiting  <= 1'b0;
            phase    <= SETUP;
            step     <= 5'd0;
            pix_cnt  <= '0;
            wait_cnt <= '0;
        end else if (!busy) begin
            if (start) begin
                busy    <= 1'b1;
                step    <= 5'd0;
                pix_cnt <= '0;
                phase   <= SETUP;
            end
        end else if (waiting) begin
            if (wait_cnt == WAIT_W'(WAIT_CYCLES - 1)) begin
                waiting <= 1'b0;
                step    <= step + 5'd1;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end else begin
            case (phase)
                SETUP: if (bus.grant) phase <= STROBE;
                STROBE: begin
                    phase <= SETUP;
                    if (step == 5'd0 || step == 5'd1) begin
                        waiting  <= 1'b1;  // after SWRESET and SLPOUT.
                        wait_cnt <= '0;
                    end else if (step != STEP_PIX) begin
                        step <= step + 5'd1;
                    end else if (pix_cnt == PIX_W'(CLEAR_BYTES - 1)) begin
                        phase <= FINISH;
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                end
                FINISH: begin
                    busy  <= 1'b0;
                    phase <= SETUP;
                end
                default: phase <= SETUP;
            endcase
        end
    end

    assign bus.req      = busy;
    assign bus.byte_out = cur;
    assign bus.wr       = (phase == STROBE);
    assign done         = (phase == FINISH);

endmodule

`default_nettype wire

/* design/lcd_bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module lcd_bus_arbiter import lcd_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    lcd_bus_if.arbiter init_bus,
    lcd_bus_if.arbiter paint_bus,
    output lcd_byte_t  pin_byte,
    output logic       pin_wr
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_INIT,
        OWN_PAINT
    } owner_t;

    owner_t owner;

    // owner locks until its client lets go of req.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            owner <= OWN_NONE;
        end else begin
            case (owner)
                OWN_NONE: begin
                    if (init_bus.req)
                        owner <= OWN_INIT;  // init wins a tie.
                    else if (paint_bus.req)
                        owner <= OWN_PAINT;
                end
                OWN_INIT:  if (!init_bus.req) owner <= OWN_NONE;
                OWN_PAINT: if (!paint_bus.req) owner <= OWN_NONE;
                default:   owner <= OWN_NONE;
            endcase
        end
    end

    assign init_bus.grant  = (owner == OWN_INIT);
    assign paint_bus.grant = (owner == OWN_PAINT);

    always_comb begin
        case (owner)
            OWN_INIT: begin
                pin_byte = init_bus.byte_out;
                pin_wr   = init_bus.wr;
            end
            OWN_PAINT: begin
                pin_byte = paint_bus.byte_out;
                pin_wr   = paint_bus.wr;
            end
            default: begin
                pin_byte = '0;
                pin_wr   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/lcd_bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface lcd_bus_if import lcd_pkg::*; ();

    logic      req;
    logic      grant;
    lcd_byte_t byte_out;
    logic      wr;

    modport client (output req, output byte_out, output wr, input grant);
    modport arbiter (input req, input byte_out, input wr, output grant);

endinterface

`default_nettype wire

/* design/lcd_display_top.sv */
`timescale 1ns/10ps
`default_nettype none

module lcd_display_top import lcd_pkg::*; #(
    parameter int GRID_W      = 16,
    parameter int GRID_H      = 12,
    parameter int TILE_PX     = 20,
    parameter int WAIT_CYCLES = 60000
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic       head,
    input  logic       body,
    input  logic       apple,
    input  logic       border,
    input  logic       game_over,
    input  logic       restart_btn,
    output logic [3:0] x,
    output logic [3:0] y,
    output logic [7:0] d,
    output logic       dcx,
    output logic       wr
);

    logic      restart_pulse;
    logic      init_start;
    logic      init_done;
    logic      paint_start;
    logic      paint_done;
    logic      scan_en;
    logic      frame_clear;
    logic      cell_changed;
    obj_t      cell_obj;
    lcd_byte_t pin_byte;

    lcd_bus_if init_bus ();
    lcd_bus_if paint_bus ();

    button_sync button_sync_i (
        .clk  (clk),
        .nrst (nrst),
        .btn  (restart_btn),
        .rise (restart_pulse)
    );

    display_control display_control_i (
        .clk           (clk),
        .nrst          (nrst),
        .init_done     (init_done),
        .paint_done    (paint_done),
        .cell_changed  (cell_changed),
        .game_over     (game_over),
        .restart_pulse (restart_pulse),
        .init_start    (init_start),
        .paint_start   (paint_start),
        .scan_en       (scan_en),
        .frame_clear   (frame_clear)
    );

    frame_tracker #(
        .GRID_W (GRID_W),
        .GRID_H (GRID_H)
    ) frame_tracker_i (
        .clk          (clk),
        .nrst         (nrst),
        .scan_en      (scan_en),
        .frame_clear  (frame_clear),
        .head         (head),
        .body         (body),
        .apple        (apple),
        .border       (border),
        .x            (x),
        .y            (y),
        .cell_obj     (cell_obj),
        .cell_changed (cell_changed)
    );

    init_sequencer #(
        .GRID_W      (GRID_W),
        .GRID_H      (GRID_H),
        .TILE_PX     (TILE_PX),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) init_sequencer_i (
        .clk   (clk),
        .nrst  (nrst),
        .start (init_start),
        .bus   (init_bus),
        .done  (init_done)
    );

    tile_painter #(
        .TILE_PX (TILE_PX)
    ) tile_painter_i (
        .clk   (clk),
        .nrst  (nrst),
        .start (paint_start),
        .x     (x),
        .y     (y),
        .obj   (cell_obj),
        .bus   (paint_bus),
        .done  (paint_done)
    );

    lcd_bus_arbiter lcd_bus_arbiter_i (
        .clk       (clk),
        .nrst      (nrst),
        .init_bus  (init_bus),
        .paint_bus (paint_bus),
        .pin_byte  (pin_byte),
        .pin_wr    (wr)
    );

    assign d   = pin_byte.d;
    assign dcx = pin_byte.dcx;

endmodule

`default_nettype wire

/* design/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

    // ======================================================================
    // types.
    // ======================================================================
    typedef enum logic [2:0] {
        EMPTY,
        HEAD,
        BODY,
        APPLE,
        BORDER
    } obj_t;

    typedef enum logic [1:0] {
        INIT,
        LOOP,
        UPDATE,
        OVER
    } ctrl_state_t;

    typedef enum logic [1:0] {
        SETUP,
        STROBE,
        FINISH
    } wr_phase_t;

    typedef struct packed {
        logic       dcx;  // 1 = data, 0 = command.
        logic [7:0] d;
    } lcd_byte_t;

    // ======================================================================
    // command opcodes and colours.
    // ======================================================================
    localparam logic [7:0] CMD_SWRESET  = 8'h01;
    localparam logic [7:0] CMD_SLPOUT   = 8'h11;
    localparam logic [7:0] CMD_COLMOD   = 8'h3A;
    localparam logic [7:0] CMD_DISPON   = 8'h29;
    localparam logic [7:0] CMD_CASET    = 8'h2A;
    localparam logic [7:0] CMD_PASET    = 8'h2B;
    localparam logic [7:0] CMD_RAMWR    = 8'h2C;
    localparam logic [7:0] PIXEL_FORMAT = 8'h55;  // 16 bits per pixel.

    localparam logic [15:0] COLOR_EMPTY  = 16'he581;
    localparam logic [15:0] COLOR_HEAD   = 16'hf0f8;
    localparam logic [15:0] COLOR_BODY   = 16'hf800;
    localparam logic [15:0] COLOR_APPLE  = 16'h00f8;
    localparam logic [15:0] COLOR_BORDER = 16'h0000;

endpackage

`default_nettype wire

/* design/tile_painter.sv */
`timescale 1ns/10ps
`default_nettype none

module tile_painter import lcd_pkg::*; #(
    parameter int TILE_PX = 20
) (
    input  logic          clk,
    input  logic          nrst,
    input  logic          start,
    input  logic [3:0]    x,
    input  logic [3:0]    y,
    input  obj_t          obj,
    lcd_bus_if.client     bus,
    output logic          done
);

    localparam int PIX_BYTES = 2 * TILE_PX * TILE_PX;
    localparam int PIX_W     = $clog2(PIX_BYTES + 1);
    localparam logic [3:0] BYTE_PIX = 4'd11;  // header done, pixels follow.

    wr_phase_t        phase;
    logic             busy;
    logic [3:0]       byte_cnt;
    logic [PIX_W-1:0] pix_cnt;
    logic [3:0]       x_q;
    logic [3:0]       y_q;
    obj_t             obj_q;
    logic [15:0]      col_s;
    logic [15:0]      col_e;
    logic [15:0]      page_s;
    logic [15:0]      page_e;
    logic [15:0]      color;
    lcd_byte_t        cur;

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            x_q   <= x;
            y_q   <= y;
            obj_q <= obj;
        end
    end

    // ======================================================================
    // window and colour bytes.
    // ======================================================================
    always_comb begin
        col_s  = 16'(x_q * TILE_PX);
        col_e  = 16'((x_q + 1) * TILE_PX - 1);
        page_s = 16'(y_q * TILE_PX);
        page_e = 16'((y_q + 1) * TILE_PX - 1);
        case (obj_q)
            HEAD:    color = COLOR_HEAD;
            BODY:    color = COLOR_BODY;
            APPLE:   color = COLOR_APPLE;
            BORDER:  color = COLOR_BORDER;
            default: color = COLOR_EMPTY;
        endcase
        case (byte_cnt)
            4'd0:    cur = {1'b0, CMD_CASET};
            4'd1:    cur = {1'b1, col_s[15:8]};
            4'd2:    cur = {1'b1, col_s[7:0]};
            4'd3:    cur = {1'b1, col_e[15:8]};
            4'd4:    cur = {1'b1, col_e[7:0]};
            4'd5:    cur = {1'b0, CMD_PASET};
            4'd6:    cur = {1'b1, page_s[15:8]};
            4'd7:    cur = {1'b1, page_s[7:0]};
            4'd8:    cur = {1'b1, page_e[15:8]};
            4'd9:    cur = {1'b1, page_e[7:0]};
            4'd10:   cur = {1'b0, CMD_RAMWR};
            default: cur = {1'b1, pix_cnt[0] ? color[15:8] : color[7:0]};  // low first.
        endcase
    end

    // ======================================================================
    // byte emission.
    // ======================================================================
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            busy     <= 1'b0;
            phase    <= SETUP;
            byte_cnt <= 4'd0;
            pix_cnt  <= '0;
        end else if (!busy) begin
            if (start) begin
                busy     <= 1'b1;
                phase    <= SETUP;
                byte_cnt <= 4'd0;
                pix_cnt  <= '0;
            end
        end else begin
            case (phase)
                SETUP: if (bus.grant) phase <= STROBE;
                STROBE: begin
                    phase <= SETUP;
                    if (byte_cnt != BYTE_PIX)
                        byte_cnt <= byte_cnt + 4'd1;
                    else if (pix_cnt == PIX_W'(PIX_BYTES - 1))
                        phase <= FINISH;
                    else
                        pix_cnt <= pix_cnt + 1'b1;
                end
                FINISH: begin
                    busy  <= 1'b0;
                    phase <= SETUP;
                end
                default: phase <= SETUP;
            endcase
        end
    end

    assign bus.req      = busy;
    assign bus.byte_out = cur;
    assign bus.wr       = (phase == STROBE);
    assign done         = (phase == FINISH);

endmodule

`default_nettype wire

/* files.f */
design/lcd_pkg.sv
design/lcd_bus_if.sv
design/button_sync.sv
design/frame_tracker.sv
design/init_sequencer.sv
design/tile_painter.sv
design/lcd_bus_arbiter.sv
design/display_control.sv
design/lcd_display_top.sv
test/tb_lcd_display.sv

/* test/tb_lcd_display.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_lcd_display import lcd_pkg::*; ();

    localparam int GRID_W      = 16;
    localparam int GRID_H      = 12;
    localparam int TILE_PX     = 2;
    localparam int WAIT_CYCLES = 50;
    localparam int CELLS       = GRID_W * GRID_H;
    localparam int N_SINGLE    = 20;
    localparam int N_MULTI     = 6;
    localparam int N_BATCH     = 6;
    localparam int N_EDITS     = N_SINGLE + N_MULTI + 2 * N_BATCH;
    localparam int INIT_CYC    = 2 * (16 + 2 * CELLS * TILE_PX * TILE_PX) + 2 * WAIT_CYCLES + 8;
    localparam int TILE_CYC    = 22 + 4 * TILE_PX * TILE_PX + 4;
    localparam int LIMIT       = 2 * (2 * INIT_CYC + 6 * CELLS
                                 + N_EDITS * (CELLS + TILE_CYC + 5) + CELLS * TILE_CYC + 4 * CELLS);

    logic       clk;
    logic       nrst;
    logic       head;
    logic       body;
    logic       apple;
    logic       border;
    logic       game_over;
    logic       restart_btn;
    logic [3:0] x;
    logic [3:0] y;
    logic [7:0] d;
    logic       dcx;
    logic       wr;

    logic       go_r;
    logic       btn_r;
    logic [3:0] grid [GRID_H][GRID_W];  // {border, head, body, apple}.
    lcd_byte_t  exp_q [$];
    lcd_byte_t  rx_q [$];
    lcd_byte_t  got_b;
    int         exp_cnt [5];
    int         got_cnt [5];
    int         value_errs;
    int         other_errs;
    int         cycles;
    logic [3:0]  prev_x;
    logic [3:0]  prev_y;
    logic [7:0]  last_cmd;
    logic [7:0]  lo_byte;
    logic [31:0] win;
    int          didx;

    lcd_display_top #(
        .GRID_W      (GRID_W),
        .GRID_H      (GRID_H),
        .TILE_PX     (TILE_PX),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) lcd_display_top_i (
        .clk         (clk),
        .nrst        (nrst),
        .head        (head),
        .body        (body),
        .apple       (apple),
        .border      (border),
        .game_over   (game_over),
        .restart_btn (restart_btn),
        .x           (x),
        .y           (y),
        .d           (d),
        .dcx         (dcx),
        .wr          (wr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ======================================================================
    // reference model.
    // ======================================================================
    function automatic obj_t resolve(logic [3:0] m);
        if (m[3]) return BORDER;
        if (m[2]) return HEAD;
        if (m[1]) return BODY;
        if (m[0]) return APPLE;
        return EMPTY;
    endfunction

    function automatic logic [15:0] color_of(obj_t o);
        case (o)
            HEAD:    return 16'hf0f8;
            BODY:    return 16'hf800;
            APPLE:   return 16'h00f8;
            BORDER:  return 16'h0000;
            default: return 16'he581;
        endcase
    endfunction

    function automatic obj_t obj_of(logic [15:0] c);
        for (int i = 0; i < 5; i++)
            if (color_of(obj_t'(i)) == c) return obj_t'(i);
        return EMPTY;
    endfunction

    function automatic void queue_byte(logic dcx_v, logic [7:0] v);
        exp_q.push_back(lcd_byte_t'({dcx_v, v}));
    endfunction

    function automatic void window_bytes(logic [7:0] cmd, int s, int e);
        queue_byte(1'b0, cmd);
        queue_byte(1'b1, s[15:8]);  // high byte first.
        queue_byte(1'b1, s[7:0]);
        queue_byte(1'b1, e[15:8]);
        queue_byte(1'b1, e[7:0]);
    endfunction

    function automatic void init_bytes();
        logic [15:0] c;
        c = color_of(EMPTY);
        queue_byte(1'b0, 8'h01);
        queue_byte(1'b0, 8'h11);
        queue_byte(1'b0, 8'h3A);
        queue_byte(1'b1, 8'h55);
        queue_byte(1'b0, 8'h29);
        window_bytes(8'h2A, 0, GRID_W * TILE_PX - 1);
        window_bytes(8'h2B, 0, GRID_H * TILE_PX - 1);
        queue_byte(1'b0, 8'h2C);
        for (int i = 0; i < CELLS * TILE_PX * TILE_PX; i++) begin
            queue_byte(1'b1, c[7:0]);
            queue_byte(1'b1, c[15:8]);
        end
    endfunction

    function automatic void tile_bytes(int cx, int cy, obj_t o);
        logic [15:0] c;
        c = color_of(o);
        window_bytes(8'h2A, cx * TILE_PX, (cx + 1) * TILE_PX - 1);  // columns from x.
        window_bytes(8'h2B, cy * TILE_PX, (cy + 1) * TILE_PX - 1);
        queue_byte(1'b0, 8'h2C);
        for (int i = 0; i < TILE_PX * TILE_PX; i++) begin
            queue_byte(1'b1, c[7:0]);
            queue_byte(1'b1, c[15:8]);
        end
        exp_cnt[int'(o)]++;
    endfunction

    // ======================================================================
    // checks.
    // ======================================================================
    task automatic check_byte(input string name, input lcd_byte_t exp_b, input lcd_byte_t act);
        if (exp_b !== act) begin
            value_errs++;
            $display("ERR %0t %s: expected %h, got %h", $time, name, exp_b, act);
        end
    endtask

    task automatic check_obj_count(input obj_t o, input int exp_n, input int act_n);
        if (exp_n != act_n) begin
            value_errs++;
            $display("ERR %0t repaints_%s: expected %0d, got %0d", $time, o.name(), exp_n, act_n);
        end
    endtask

    task automatic check_pos(input string name, input logic [3:0] exp_v, input logic [3:0] act);
        if (exp_v !== act) begin
            value_errs++;
            $display("ERR %0t %s: expected %0d, got %0d", $time, name, exp_v, act);
        end
    endtask

    // tile windows are TILE_PX wide, the clear window is the whole screen.
    task automatic count_repaint(input lcd_byte_t b);
        logic [15:0] c;
        if (!b.dcx) begin
            last_cmd = b.d;
            didx = 0;
        end else begin
            if (last_cmd == CMD_CASET) begin
                win = {win[23:0], b.d};
            end else if (last_cmd == CMD_RAMWR && didx == 0) begin
                lo_byte = b.d;
            end else if (last_cmd == CMD_RAMWR && didx == 1) begin
                c = {b.d, lo_byte};
                if (int'(win[15:0]) - int'(win[31:16]) + 1 == TILE_PX)
                    got_cnt[int'(obj_of(c))]++;
            end
            didx++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    endtask

    // ======================================================================
    // stimulus.
    // ======================================================================
    always @(posedge clk) begin
        #2;
        if (!$isunknown({x, y}) && int'(x) < GRID_W && int'(y) < GRID_H)
            {border, head, body, apple} = grid[y][x];
        else
            {border, head, body, apple} = 4'b0000;
        game_over   = go_r;
        restart_btn = btn_r;
    end

    // scan resumes one cell past the position seen at the edit.
    task automatic edit_cells(input int n, input int min_bits, input bit expect_paint);
        bit         picked [CELLS];
        int         p;
        int         org;
        logic [3:0] m;
        @(negedge clk);
        org = (int'(y) * GRID_W + int'(x) + 1) % CELLS;
        foreach (picked[i]) picked[i] = 1'b0;
        for (int k = 0; k < n; k++) begin
            do p = $urandom % CELLS; while (picked[p]);
            do m = 4'($urandom);
            while ($countones(m) < min_bits || resolve(m) == resolve(grid[p / GRID_W][p % GRID_W]));
            grid[p / GRID_W][p % GRID_W] = m;
            picked[p] = 1'b1;
        end
        if (expect_paint) begin
            for (int k = 0; k < CELLS; k++) begin
                p = (org + k) % CELLS;
                if (picked[p])
                    tile_bytes(p % GRID_W, p / GRID_W, resolve(grid[p / GRID_W][p % GRID_W]));
            end
        end
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);  // back in LOOP.
    endtask

    // ======================================================================
    // monitor, compare and watchdog.
    // ======================================================================
    always @(negedge clk) begin
        if (wr === 1'b1)
            rx_q.push_back(lcd_byte_t'({dcx, d}));
    end

    // the scan holds, steps to the next cell, or restarts at (0,0).
    always @(negedge clk) begin
        logic [3:0] nx;
        logic [3:0] ny;
        nx = (int'(prev_x) == GRID_W - 1) ? 4'd0 : prev_x + 4'd1;
        if (int'(prev_x) != GRID_W - 1)
            ny = prev_y;
        else
            ny = (int'(prev_y) == GRID_H - 1) ? 4'd0 : prev_y + 4'd1;
        if (nrst === 1'b1 && {x, y} !== {prev_x, prev_y} && {x, y} !== 8'h00) begin
            check_pos("x", nx, x);
            check_pos("y", ny, y);
        end
        prev_x = x;
        prev_y = y;
    end

    always @(posedge clk) begin
        while (rx_q.size() > 0) begin
            got_b = rx_q.pop_front();
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("unexpected LCD write at %0t: dcx %b d %h", $time, got_b.dcx, got_b.d);
            end else begin
                check_byte("lcd_byte", exp_q.pop_front(), got_b);
            end
            count_repaint(got_b);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            other_errs++;
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            finish_run();
        end
    end

    initial begin
        void'($urandom(65208));
        nrst        = 1'b0;
        head        = 1'b0;
        body        = 1'b0;
        apple       = 1'b0;
        border      = 1'b0;
        game_over   = 1'b0;
        restart_btn = 1'b0;
        go_r        = 1'b0;
        btn_r       = 1'b0;
        value_errs  = 0;
        other_errs  = 0;
        cycles      = 0;
        prev_x      = 4'd0;
        prev_y      = 4'd0;
        last_cmd    = 8'h00;
        lo_byte     = 8'h00;
        win         = 32'h0;
        didx        = 0;
        foreach (grid[i, j]) grid[i][j] = 4'b0000;
        foreach (exp_cnt[i]) begin
            exp_cnt[i] = 0;
            got_cnt[i] = 0;
        end
        repeat (3) @(posedge clk);
        #2 nrst = 1'b1;
        init_bytes();
        wait_idle();
        repeat (3 * CELLS) @(negedge clk);  // empty grid, no writes.
        repeat (N_SINGLE) begin
            edit_cells(1, 0, 1'b1);
            wait_idle();
        end
        repeat (N_MULTI) begin
            edit_cells(1, 2, 1'b1);
            wait_idle();
        end
        repeat (2) begin
            edit_cells(N_BATCH, 0, 1'b1);
            wait_idle();
        end
        go_r = 1'b1;
        repeat (5) @(negedge clk);
        edit_cells(4, 0, 1'b0);
        repeat (2 * CELLS) @(negedge clk);
        go_r = 1'b0;
        repeat (3) @(negedge clk);
        init_bytes();
        for (int p = 0; p < CELLS; p++)
            if (resolve(grid[p / GRID_W][p % GRID_W]) != EMPTY)
                tile_bytes(p % GRID_W, p / GRID_W, resolve(grid[p / GRID_W][p % GRID_W]));
        btn_r = 1'b1;
        repeat (3) @(negedge clk);
        btn_r = 1'b0;
        wait_idle();
        for (int i = 0; i < 5; i++)
            check_obj_count(obj_t'(i), exp_cnt[i], got_cnt[i]);
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("%0d expected LCD bytes never arrived", exp_q.size());
        end
        finish_run();
    end

endmodule

`default_nettype wire
